// ==== common/noc_pkg.sv ====
// mesh router shared definitions
// port directions of the five-port router and the fixed port count
// the same encoding names an input port and an output port

`default_nettype none

package noc_pkg;

  // port direction, used as index into every per-port array
  // eject is the local endpoint attached to this router
  // x grows towards east, y grows towards north
  typedef enum logic [2:0] {
    Eject = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  // one port per direction above
  localparam int NumPorts = 5;

endpackage

`default_nettype wire

// ==== hdl/noc_in_buffer.sv ====
// router input buffer
// small circular FIFO holding the flits of one input port
// head flit fields are visible combinationally on the pop side

`timescale 1ns/1ps
`default_nettype none

module noc_in_buffer #(
  parameter int unsigned DataWidth  = 16,
  parameter int unsigned CoordWidth = 3,
  parameter int unsigned FifoDepth  = 2
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // push side, from the link
  input  logic                  valid_i,
  output logic                  ready_o,
  input  logic [DataWidth-1:0]  data_i,
  input  logic [CoordWidth-1:0] dst_x_i,
  input  logic [CoordWidth-1:0] dst_y_i,
  input  logic                  last_i,
  // pop side, towards route select and arbiters
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic [DataWidth-1:0]  data_o,
  output logic [CoordWidth-1:0] dst_x_o,
  output logic [CoordWidth-1:0] dst_y_o,
  output logic                  last_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  // flit storage, one array per field
  logic [DataWidth-1:0]  data_mem  [FifoDepth];
  logic [CoordWidth-1:0] dst_x_mem [FifoDepth];
  logic [CoordWidth-1:0] dst_y_mem [FifoDepth];
  logic                  last_mem  [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // accept while not full, offer while not empty
  assign ready_o = (count_q != CntWidth'(FifoDepth));
  assign valid_o = (count_q != '0);
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  // head entry
  assign data_o  = data_mem[rd_ptr_q];
  assign dst_x_o = dst_x_mem[rd_ptr_q];
  assign dst_y_o = dst_y_mem[rd_ptr_q];
  assign last_o  = last_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // pointers wrap at the last entry, depth need not be a power of two
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_mem[wr_ptr_q]  <= data_i;
      dst_x_mem[wr_ptr_q] <= dst_x_i;
      dst_y_mem[wr_ptr_q] <= dst_y_i;
      last_mem[wr_ptr_q]  <= last_i;
    end
  end

  // pop-ready comes from the arbiters through the top level
  // a grant needs a waiting head flit, so an empty buffer never sees it
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    ready_i |-> valid_o)
    else $error("pop-ready raised on an empty input buffer");

endmodule

`default_nettype wire

// ==== hdl/noc_route_select.sv ====
// XY route selector for one router input
// picks the output port of the head flit by dimension-ordered routing
// and keeps that choice until the last flit of the packet has left

`timescale 1ns/1ps
`default_nettype none

module noc_route_select #(
  parameter int unsigned CoordWidth = 3
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // router position in the mesh, static while running
  input  logic [CoordWidth-1:0]        local_x_i,
  input  logic [CoordWidth-1:0]        local_y_i,
  // head flit fields of the input buffer
  input  logic [CoordWidth-1:0]        dst_x_i,
  input  logic [CoordWidth-1:0]        dst_y_i,
  input  logic                         last_i,
  // handshake at the buffer pop side
  input  logic                         valid_i,
  input  logic                         ready_i,
  // one-hot output port
  output logic [noc_pkg::NumPorts-1:0] route_sel_o
);

  noc_pkg::route_dir_e          route_dir;
  logic [noc_pkg::NumPorts-1:0] route_sel;
  logic [noc_pkg::NumPorts-1:0] route_sel_q;
  logic                         locked_d;
  logic                         locked_q;

  // x first, then y, eject once both match
  always_comb begin : proc_xy
    if (dst_x_i > local_x_i) begin
      route_dir = noc_pkg::East;
    end else if (dst_x_i < local_x_i) begin
      route_dir = noc_pkg::West;
    end else if (dst_y_i > local_y_i) begin
      route_dir = noc_pkg::North;
    end else if (dst_y_i < local_y_i) begin
      route_dir = noc_pkg::South;
    end else begin
      route_dir = noc_pkg::Eject;
    end
  end

  // direction to one-hot
  always_comb begin : proc_onehot
    route_sel            = '0;
    route_sel[route_dir] = 1'b1;
  end

  // lock rises after a non-last flit leaves and drops after the last one
  // a single-flit packet never locks
  always_comb begin : proc_lock
    locked_d = locked_q;
    if (valid_i && ready_i) begin
      locked_d = ~last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      locked_q <= 1'b0;
    end else begin
      locked_q <= locked_d;
    end
  end

  // capture the head route while unlocked
  // frozen for the body flits, whatever their destination fields hold
  always_ff @(posedge clk_i) begin
    if (!locked_q) begin
      route_sel_q <= route_sel;
    end
  end

  assign route_sel_o = locked_q ? route_sel_q : route_sel;

  // holds for the live route and for the one kept across the packet
  a_route_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    valid_i |-> $onehot(route_sel_o))
    else $error("route selection is not one-hot");

endmodule

`default_nettype wire

// ==== noc_router/noc_out_arbiter.sv ====
// output port arbiter
// round-robin choice among the five inputs requesting this output
// the grant stays with one input for a whole packet, flits never interleave

`timescale 1ns/1ps
`default_nettype none

module noc_out_arbiter #(
  parameter int unsigned DataWidth  = 16,
  parameter int unsigned CoordWidth = 3
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // bit p set when input p holds a flit routed here
  input  logic [noc_pkg::NumPorts-1:0] req_i,
  // head flit fields of every input
  input  logic [DataWidth-1:0]         in_data_i  [noc_pkg::NumPorts],
  input  logic [CoordWidth-1:0]        in_dst_x_i [noc_pkg::NumPorts],
  input  logic [CoordWidth-1:0]        in_dst_y_i [noc_pkg::NumPorts],
  input  logic [noc_pkg::NumPorts-1:0] in_last_i,
  // output link
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic [DataWidth-1:0]         out_data_o,
  output logic [CoordWidth-1:0]        out_dst_x_o,
  output logic [CoordWidth-1:0]        out_dst_y_o,
  output logic                         out_last_o,
  // bit p set when input p is served
  output logic [noc_pkg::NumPorts-1:0] grant_o
);

  noc_pkg::route_dir_e rr_d;
  noc_pkg::route_dir_e rr_q;
  noc_pkg::route_dir_e rr_winner;
  noc_pkg::route_dir_e rr_next;
  noc_pkg::route_dir_e win_port;
  noc_pkg::route_dir_e lock_port_d;
  noc_pkg::route_dir_e lock_port_q;
  logic                locked_d;
  logic                locked_q;
  logic                win_valid;
  logic                xfer;

  // first requester at or after the pointer
  always_comb begin : proc_pick
    int   idx;
    logic found;
    found     = 1'b0;
    rr_winner = rr_q;
    for (int i = 0; i < noc_pkg::NumPorts; i++) begin
      idx = (int'(rr_q) + i) % noc_pkg::NumPorts;
      if (!found && req_i[idx]) begin
        found     = 1'b1;
        rr_winner = noc_pkg::route_dir_e'(idx);
      end
    end
  end

  // while locked only the packet owner may be served
  assign win_port  = locked_q ? lock_port_q : rr_winner;
  assign win_valid = req_i[win_port];
  assign xfer      = out_valid_o && out_ready_i;

  always_comb begin : proc_grant
    grant_o           = '0;
    grant_o[win_port] = win_valid;
  end

  // flit mux
  assign out_valid_o = win_valid;
  assign out_data_o  = in_data_i[win_port];
  assign out_dst_x_o = in_dst_x_i[win_port];
  assign out_dst_y_o = in_dst_y_i[win_port];
  assign out_last_o  = in_last_i[win_port];

  // priority moves to the port after the winner
  assign rr_next = (win_port == noc_pkg::route_dir_e'(noc_pkg::NumPorts - 1)) ?
                   noc_pkg::Eject : noc_pkg::route_dir_e'(win_port + 1'b1);

  // lock as soon as a head flit is offered, so a stalled offer keeps its
  // fields until taken, and release on the transfer of the last flit
  always_comb begin : proc_lock
    locked_d    = locked_q;
    lock_port_d = locked_q ? lock_port_q : rr_winner;
    rr_d        = rr_q;
    if (xfer && out_last_o) begin
      locked_d = 1'b0;
      rr_d     = rr_next;
    end else if (win_valid) begin
      locked_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      locked_q    <= 1'b0;
      lock_port_q <= noc_pkg::Eject;
      rr_q        <= noc_pkg::Eject;
    end else begin
      locked_q    <= locked_d;
      lock_port_q <= lock_port_d;
      rr_q        <= rr_d;
    end
  end

  a_grant_onehot0: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(grant_o))
    else $error("more than one input granted");

  // a stalled flit stays put, which needs the buffer head, the route lock
  // and this grant lock to hold together
  a_out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o) &&
    $stable(out_dst_x_o) && $stable(out_dst_y_o) && $stable(out_last_o))
    else $error("output flit changed while stalled");

endmodule

`default_nettype wire

// ==== noc_router/noc_router.sv ====
// five-port mesh router
// per input a flit buffer and an XY route selector, per output a
// round-robin arbiter that holds its grant for a whole packet

`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter int unsigned DataWidth  = 16,
  parameter int unsigned CoordWidth = 3,
  parameter int unsigned FifoDepth  = 2
) (
  input  logic                         clk_i,
  input  logic                         reset_i,
  // router coordinates
  input  logic [CoordWidth-1:0]        local_x_i,
  input  logic [CoordWidth-1:0]        local_y_i,
  // input links, indexed by route_dir_e
  input  logic [noc_pkg::NumPorts-1:0] in_valid_i,
  output logic [noc_pkg::NumPorts-1:0] in_ready_o,
  input  logic [DataWidth-1:0]         in_data_i  [noc_pkg::NumPorts],
  input  logic [CoordWidth-1:0]        in_dst_x_i [noc_pkg::NumPorts],
  input  logic [CoordWidth-1:0]        in_dst_y_i [noc_pkg::NumPorts],
  input  logic [noc_pkg::NumPorts-1:0] in_last_i,
  // output links, indexed by route_dir_e
  output logic [noc_pkg::NumPorts-1:0] out_valid_o,
  input  logic [noc_pkg::NumPorts-1:0] out_ready_i,
  output logic [DataWidth-1:0]         out_data_o  [noc_pkg::NumPorts],
  output logic [CoordWidth-1:0]        out_dst_x_o [noc_pkg::NumPorts],
  output logic [CoordWidth-1:0]        out_dst_y_o [noc_pkg::NumPorts],
  output logic [noc_pkg::NumPorts-1:0] out_last_o
);

  // buffer heads, one per input
  logic [noc_pkg::NumPorts-1:0] buf_valid;
  logic [noc_pkg::NumPorts-1:0] buf_ready;
  logic [DataWidth-1:0]         buf_data  [noc_pkg::NumPorts];
  logic [CoordWidth-1:0]        buf_dst_x [noc_pkg::NumPorts];
  logic [CoordWidth-1:0]        buf_dst_y [noc_pkg::NumPorts];
  logic [noc_pkg::NumPorts-1:0] buf_last;

  // route_sel[p][o] input p heads for output o
  logic [noc_pkg::NumPorts-1:0] route_sel [noc_pkg::NumPorts];
  // req[o][p] and grant[o][p] seen from output o
  logic [noc_pkg::NumPorts-1:0] req       [noc_pkg::NumPorts];
  logic [noc_pkg::NumPorts-1:0] grant     [noc_pkg::NumPorts];

  for (genvar p = 0; p < noc_pkg::NumPorts; p++) begin : gen_input
    noc_in_buffer #(
      .DataWidth  (DataWidth),
      .CoordWidth (CoordWidth),
      .FifoDepth  (FifoDepth)
    ) i_buffer (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (in_valid_i[p]),
      .ready_o (in_ready_o[p]),
      .data_i  (in_data_i[p]),
      .dst_x_i (in_dst_x_i[p]),
      .dst_y_i (in_dst_y_i[p]),
      .last_i  (in_last_i[p]),
      .valid_o (buf_valid[p]),
      .ready_i (buf_ready[p]),
      .data_o  (buf_data[p]),
      .dst_x_o (buf_dst_x[p]),
      .dst_y_o (buf_dst_y[p]),
      .last_o  (buf_last[p])
    );

    noc_route_select #(
      .CoordWidth (CoordWidth)
    ) i_route (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .local_x_i   (local_x_i),
      .local_y_i   (local_y_i),
      .dst_x_i     (buf_dst_x[p]),
      .dst_y_i     (buf_dst_y[p]),
      .last_i      (buf_last[p]),
      .valid_i     (buf_valid[p]),
      .ready_i     (buf_ready[p]),
      .route_sel_o (route_sel[p])
    );
  end

  // an input requests the output its head flit is routed to
  always_comb begin : proc_req
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      for (int p = 0; p < noc_pkg::NumPorts; p++) begin
        req[o][p] = buf_valid[p] & route_sel[p][o];
      end
    end
  end

  // pop when the granting output takes the flit
  always_comb begin : proc_pop
    buf_ready = '0;
    for (int o = 0; o < noc_pkg::NumPorts; o++) begin
      for (int p = 0; p < noc_pkg::NumPorts; p++) begin
        buf_ready[p] = buf_ready[p] | (grant[o][p] & out_ready_i[o]);
      end
    end
  end

  for (genvar o = 0; o < noc_pkg::NumPorts; o++) begin : gen_output
    noc_out_arbiter #(
      .DataWidth  (DataWidth),
      .CoordWidth (CoordWidth)
    ) i_arbiter (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_i       (req[o]),
      .in_data_i   (buf_data),
      .in_dst_x_i  (buf_dst_x),
      .in_dst_y_i  (buf_dst_y),
      .in_last_i   (buf_last),
      .out_valid_o (out_valid_o[o]),
      .out_ready_i (out_ready_i[o]),
      .out_data_o  (out_data_o[o]),
      .out_dst_x_o (out_dst_x_o[o]),
      .out_dst_y_o (out_dst_y_o[o]),
      .out_last_o  (out_last_o[o]),
      .grant_o     (grant[o])
    );
  end

endmodule

`default_nettype wire

// ==== verif/tb_noc_router.sv ====
// testbench for the five-port mesh router
// directed tests with an XY reference model and per-source scoreboard queues
// every flit carries its source port and a sequence number in its data

`timescale 1ns/1ps
`default_nettype none

module tb_noc_router;

  localparam int DataWidth   = 16;
  localparam int CoordWidth  = 3;
  localparam int NumPorts    = noc_pkg::NumPorts;
  localparam int ClkPeriod   = 20;
  localparam int ResetCycles = 8;
  localparam int Rounds      = 3;
  localparam int RandPkts    = 8;
  // upper bound of flits sent over the whole run, times a per-flit cycle budget
  localparam int TotalFlits  = 5 + 4 + 2 * 3 * Rounds + 6 + NumPorts * RandPkts * 4;
  localparam int FlitBound   = 30;
  localparam int WatchdogNs  = (TotalFlits * FlitBound + ResetCycles) * ClkPeriod;
  localparam logic [CoordWidth-1:0] LocalX = 3'd2;
  localparam logic [CoordWidth-1:0] LocalY = 3'd2;

  // one expected flit, with the output it must leave on
  typedef struct packed {
    noc_pkg::route_dir_e   dir;
    logic                  last;
    logic [CoordWidth-1:0] dx;
    logic [CoordWidth-1:0] dy;
    logic [DataWidth-1:0]  data;
  } flit_t;

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic [NumPorts-1:0]   in_valid_i;
  logic [NumPorts-1:0]   in_ready_o;
  logic [DataWidth-1:0]  in_data_i  [NumPorts];
  logic [CoordWidth-1:0] in_dst_x_i [NumPorts];
  logic [CoordWidth-1:0] in_dst_y_i [NumPorts];
  logic [NumPorts-1:0]   in_last_i;
  logic [NumPorts-1:0]   out_valid_o;
  logic [NumPorts-1:0]   out_ready_i;
  logic [DataWidth-1:0]  out_data_o  [NumPorts];
  logic [CoordWidth-1:0] out_dst_x_o [NumPorts];
  logic [CoordWidth-1:0] out_dst_y_o [NumPorts];
  logic [NumPorts-1:0]   out_last_o;

  // scoreboard, one queue per source since a buffer keeps its order
  flit_t         exp_q [NumPorts][$];
  int            win_log [$];
  int            seq_cnt [NumPorts];
  int            pkt_src [NumPorts];
  logic [NumPorts-1:0] in_pkt;
  logic [15:0]   lfsr_q = 16'd71;
  int            err_cnt = 0;
  int            check_cnt = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  int            senders_done;

  noc_router #(
    .DataWidth  (DataWidth),
    .CoordWidth (CoordWidth),
    .FifoDepth  (2)
  ) i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .local_x_i   (LocalX),
    .local_y_i   (LocalY),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .in_dst_x_i  (in_dst_x_i),
    .in_dst_y_i  (in_dst_y_i),
    .in_last_i   (in_last_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o),
    .out_dst_x_o (out_dst_x_o),
    .out_dst_y_o (out_dst_y_o),
    .out_last_o  (out_last_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic int lfsr_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_step());
    end
    return v;
  endfunction

  // reference XY rule: x first, then y, eject on a match
  function automatic noc_pkg::route_dir_e xy_route(input logic [CoordWidth-1:0] dx,
                                                   input logic [CoordWidth-1:0] dy);
    if (dx > LocalX) return noc_pkg::East;
    if (dx < LocalX) return noc_pkg::West;
    if (dy > LocalY) return noc_pkg::North;
    if (dy < LocalY) return noc_pkg::South;
    return noc_pkg::Eject;
  endfunction

  task automatic check_dir(input string name, input noc_pkg::route_dir_e want,
                           input noc_pkg::route_dir_e got);
    check_cnt++;
    if (want != got) begin
      $display("ERROR %0t: %s expected %s actual %s", $time, name, want.name(), got.name());
      err_cnt++;
    end
  endtask

  task automatic check_data(input string name, input logic [DataWidth-1:0] want,
                            input logic [DataWidth-1:0] got);
    check_cnt++;
    if (want !== got) begin
      $display("ERROR %0t: %s expected %h actual %h", $time, name, want, got);
      err_cnt++;
    end
  endtask

  task automatic check_coord(input string name, input logic [CoordWidth-1:0] want,
                             input logic [CoordWidth-1:0] got);
    check_cnt++;
    if (want !== got) begin
      $display("ERROR %0t: %s expected %0d actual %0d", $time, name, want, got);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic want, input logic got);
    check_cnt++;
    if (want !== got) begin
      $display("ERROR %0t: %s expected %b actual %b", $time, name, want, got);
      err_cnt++;
    end
  endtask

  // output monitor, sampled mid-cycle where valid and ready are settled
  always @(negedge clk_i) begin : monitor
    flit_t want;
    int    src;
    if (!reset_i) begin
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid_o[o] && out_ready_i[o]) begin
          src = int'(out_data_o[o][DataWidth-1 -: 3]);
          if (src >= NumPorts || exp_q[src].size() == 0) begin
            $display("unexpected flit %h on output %0d at %0t", out_data_o[o], o, $time);
            err_cnt++;
          end else begin
            if (in_pkt[o] && src != pkt_src[o]) begin
              $display("output %0d interleaved inputs %0d and %0d at %0t",
                       o, pkt_src[o], src, $time);
              err_cnt++;
            end
            // head flits on east give the arbitration order
            if (!in_pkt[o] && o == int'(noc_pkg::East)) begin
              win_log.push_back(src);
            end
            want = exp_q[src].pop_front();
            check_dir("output port", want.dir, noc_pkg::route_dir_e'(o));
            check_data("out_data_o", want.data, out_data_o[o]);
            check_coord("out_dst_x_o", want.dx, out_dst_x_o[o]);
            check_coord("out_dst_y_o", want.dy, out_dst_y_o[o]);
            check_bit("out_last_o", want.last, out_last_o[o]);
            in_pkt[o]  = !out_last_o[o];
            pkt_src[o] = src;
          end
        end
      end
    end
  end

  // one packet into input port, scramble changes the body destinations
  task automatic send_packet(input int port, input int len, input logic [CoordWidth-1:0] dx,
                             input logic [CoordWidth-1:0] dy, input logic scramble);
    flit_t f;
    logic  accepted;
    for (int i = 0; i < len; i++) begin
      f.dir  = xy_route(dx, dy);
      f.last = (i == len - 1);
      f.dx   = (scramble && i > 0) ? dx + 3'(i) : dx;
      f.dy   = (scramble && i > 0) ? dy - 3'(i) : dy;
      f.data = {3'(port), 13'(seq_cnt[port])};
      seq_cnt[port]++;
      exp_q[port].push_back(f);
      in_data_i[port]  = f.data;
      in_dst_x_i[port] = f.dx;
      in_dst_y_i[port] = f.dy;
      in_last_i[port]  = f.last;
      in_valid_i[port] = 1'b1;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk_i);
        accepted = in_ready_o[port];
        @(posedge clk_i);
        #2;
      end
    end
    in_valid_i[port] = 1'b0;
  endtask

  function automatic logic queues_empty();
    for (int p = 0; p < NumPorts; p++) begin
      if (exp_q[p].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  // wait until every sent flit has come out
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (!queues_empty() && cycles < 200) begin
      @(posedge clk_i);
      cycles++;
    end
    #2;
    if (!queues_empty()) begin
      $display("flits still missing after %0d cycles at %0t", cycles, $time);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %s ok", name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic test_reset();
    int errs;
    errs = err_cnt;
    for (int p = 0; p < NumPorts; p++) begin
      check_bit($sformatf("out_valid_o[%0d]", p), 1'b0, out_valid_o[p]);
      check_bit($sformatf("in_ready_o[%0d]", p), 1'b1, in_ready_o[p]);
    end
    report_test("reset", errs);
  endtask

  // one single-flit packet per direction from the local endpoint
  task automatic test_routing();
    int errs;
    errs = err_cnt;
    send_packet(noc_pkg::Eject, 1, 3'd3, 3'd2, 1'b0);
    send_packet(noc_pkg::Eject, 1, 3'd1, 3'd2, 1'b0);
    send_packet(noc_pkg::Eject, 1, 3'd2, 3'd3, 1'b0);
    send_packet(noc_pkg::Eject, 1, 3'd2, 3'd1, 1'b0);
    send_packet(noc_pkg::Eject, 1, 3'd2, 3'd2, 1'b0);
    wait_drain();
    report_test("routing", errs);
  endtask

  // head goes south, the body fields would point elsewhere
  task automatic test_route_lock();
    int errs;
    errs = err_cnt;
    send_packet(noc_pkg::North, 4, 3'd2, 3'd0, 1'b1);
    wait_drain();
    report_test("route_lock", errs);
  endtask

  // west and south keep east busy with back-to-back packets
  // each packet end finds the other input still waiting, so every handover is a tie
  task automatic test_contention();
    int errs;
    errs = err_cnt;
    win_log.delete();
    fork
      repeat (Rounds) send_packet(noc_pkg::West, 3, 3'd3, 3'd2, 1'b0);
      repeat (Rounds) send_packet(noc_pkg::South, 3, 3'd3, 3'd2, 1'b0);
    join
    wait_drain();
    if (win_log.size() != 2 * Rounds) begin
      $display("east saw %0d packets instead of %0d", win_log.size(), 2 * Rounds);
      err_cnt++;
    end else begin
      for (int i = 1; i < 2 * Rounds; i++) begin
        // previous winner must lose the next tie
        if (win_log[i] == win_log[i - 1]) begin
          $display("input %0d won two ties in a row at packet %0d", win_log[i], i);
          err_cnt++;
        end
      end
    end
    report_test("contention", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs = err_cnt;
    out_ready_i[noc_pkg::East] = 1'b0;
    fork
      send_packet(noc_pkg::Eject, 6, 3'd3, 3'd2, 1'b0);
      begin
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        check_bit("in_ready_o[Eject]", 1'b0, in_ready_o[noc_pkg::Eject]);
        check_bit("out_valid_o[East]", 1'b1, out_valid_o[noc_pkg::East]);
        @(posedge clk_i);
        #2;
        out_ready_i[noc_pkg::East] = 1'b1;
      end
    join
    wait_drain();
    report_test("backpressure", errs);
  endtask

  task automatic send_random(input int src);
    int len;
    logic [CoordWidth-1:0] dx;
    logic [CoordWidth-1:0] dy;
    for (int k = 0; k < RandPkts; k++) begin
      len = 1 + lfsr_bits(2);
      dx  = 3'(1 + lfsr_bits(2));
      dy  = 3'(1 + lfsr_bits(2));
      send_packet(src, len, dx, dy, 1'b0);
    end
    senders_done++;
  endtask

  // all inputs at once, outputs ready about three cycles in four
  task automatic test_random();
    int errs;
    errs = err_cnt;
    senders_done = 0;
    for (int s = 0; s < NumPorts; s++) begin
      fork
        automatic int src = s;
        send_random(src);
      join_none
    end
    while (senders_done < NumPorts) begin
      for (int o = 0; o < NumPorts; o++) begin
        out_ready_i[o] = (lfsr_bits(2) != 0);
      end
      @(posedge clk_i);
      #2;
    end
    out_ready_i = '1;
    wait_drain();
    report_test("random", errs);
  endtask

  initial begin : watchdog
    #(WatchdogNs);
    $display("timeout, the router stopped delivering flits at %0t", $time);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    reset_i     = 1'b1;
    in_valid_i  = '0;
    in_last_i   = '0;
    out_ready_i = '1;
    in_pkt      = '0;
    for (int p = 0; p < NumPorts; p++) begin
      in_data_i[p]  = '0;
      in_dst_x_i[p] = '0;
      in_dst_y_i[p] = '0;
      seq_cnt[p]    = 0;
      pkt_src[p]    = 0;
    end
    repeat (ResetCycles) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    test_reset();
    test_routing();
    test_route_lock();
    test_contention();
    test_backpressure();
    test_random();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
common/noc_pkg.sv
hdl/noc_in_buffer.sv
hdl/noc_route_select.sv
noc_router/noc_out_arbiter.sv
noc_router/noc_router.sv
verif/tb_noc_router.sv

// ==== run.sh ====
#!/bin/sh
# compile the router testbench with Verilator and run it
# the run passes only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_noc_router -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "^=== PASS ===$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
